//--- Bender.yml
package:
  name: rename_frontend

sources:
  - logic/ooo_pkg.sv
  - logic/instr_decoder.sv
  - logic/rob_tag_alloc.sv
  - logic/register_renaming.sv
  - logic/dispatch_stage.sv
  - logic/rename_top.sv
  - target: test
    files:
      - test/rename_tb.sv

//--- compile.f
logic/ooo_pkg.sv
logic/instr_decoder.sv
logic/rob_tag_alloc.sv
logic/register_renaming.sv
logic/dispatch_stage.sv
logic/rename_top.sv
test/rename_tb.sv

//--- logic/dispatch_stage.sv
`default_nettype none

module dispatch_stage (
    input  logic               clk_i,
    input  logic               rst_ni,
    input  logic               flush_i,
    input  ooo_pkg::dispatch_t dispatch_i,
    output ooo_pkg::dispatch_t dispatch_o
);

    logic               valid_q;
    ooo_pkg::dispatch_t payload_q;

    // --------------------
    // Valid bit
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= 1'b0;
        end else if (flush_i) begin
            // Squash whatever was renamed in the flush cycle
            valid_q <= 1'b0;
        end else begin
            valid_q <= dispatch_i.valid;
        end
    end

    // --------------------
    // Payload
    // --------------------

    // Hold the last packet through idle cycles to keep the data bus quiet
    always_ff @(posedge clk_i) begin
        if (dispatch_i.valid) begin
            payload_q <= dispatch_i;
        end
    end

    // Registered valid replaces the stored copy
    always_comb begin
        dispatch_o       = payload_q;
        dispatch_o.valid = valid_q;
    end

    // Reservation stations sample valid every cycle
    a_valid_known: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !$isunknown(dispatch_o.valid)
    ) else $error("dispatch valid is unknown");

endmodule

`default_nettype wire

//--- logic/instr_decoder.sv
`default_nettype none

module instr_decoder (
    input  logic                         valid_i,
    input  logic [ooo_pkg::PC_WIDTH-1:0] pc_i,
    input  ooo_pkg::instr_u              instr_i,
    output ooo_pkg::decoded_t            decoded_o
);

    // RV32I major opcodes
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;
    localparam logic [6:0] OPC_JALR   = 7'b1100111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

    logic rs1_used;
    logic rs2_used;
    logic rd_written;

    // --------------------
    // Format classification
    // --------------------
    always_comb begin
        // R-type default reads both sources and writes rd
        rs1_used   = 1'b1;
        rs2_used   = 1'b1;
        rd_written = 1'b1;
        case (instr_i.i.opcode)
            // U-type and JAL take no register source
            OPC_LUI, OPC_AUIPC, OPC_JAL: begin
                rs1_used = 1'b0;
                rs2_used = 1'b0;
            end
            // I-type formats read rs1 only
            OPC_JALR, OPC_LOAD, OPC_OP_IMM: begin
                rs2_used = 1'b0;
            end
            // S and B types have an immediate in the rd slot
            OPC_STORE, OPC_BRANCH: begin
                rd_written = 1'b0;
            end
            default: begin
            end
        endcase
    end

    // --------------------
    // Field extraction
    // --------------------
    always_comb begin
        decoded_o.valid       = valid_i;
        decoded_o.pc          = pc_i;
        decoded_o.instr       = instr_i;
        // Unused source reads as x0 so rename sees no dependency
        decoded_o.rs1_addr    = rs1_used ? instr_i.r.rs1 : '0;
        decoded_o.rs2_addr    = rs2_used ? instr_i.r.rs2 : '0;
        decoded_o.rd_addr     = instr_i.r.rd;
        decoded_o.rd_write_en = rd_written;
    end

    // Fetch side must hand over a fully driven word with its strobe
    always_comb begin
        if (valid_i) begin
            a_instr_known: assert final (!$isunknown(instr_i))
                else $error("instruction word has unknown bits while valid");
        end
    end

endmodule

`default_nettype wire

//--- logic/ooo_pkg.sv
`default_nettype none

package ooo_pkg;

    // --------------------
    // Core configuration
    // --------------------

    // Operand and result width
    localparam int DATA_WIDTH     = 32;

    // Architectural register file size and index width
    localparam int ARCH_REG_COUNT = 32;
    localparam int REG_ADDR_WIDTH = 5;

    // ROB depth, tag is the ROB slot index
    localparam int ROB_SIZE       = 8;
    localparam int ROB_TAG_WIDTH  = 3;

    localparam int PC_WIDTH       = 32;

    // --------------------
    // Instruction word
    // --------------------

    // R-type layout, also gives the register fields of every format
    typedef struct packed {
        logic [6:0]                funct7;
        logic [REG_ADDR_WIDTH-1:0] rs2;
        logic [REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0]                funct3;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [6:0]                opcode;
    } instr_r_t;

    // I-type layout with the 12 bit immediate
    typedef struct packed {
        logic [11:0]               imm12;
        logic [REG_ADDR_WIDTH-1:0] rs1;
        logic [2:0]                funct3;
        logic [REG_ADDR_WIDTH-1:0] rd;
        logic [6:0]                opcode;
    } instr_i_t;

    // Same 32 bit word seen through either layout
    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_u;

    // --------------------
    // Pipeline payloads
    // --------------------

    // Decoder output toward rename
    typedef struct packed {
        logic                      valid;
        logic [PC_WIDTH-1:0]       pc;
        instr_u                    instr;
        logic [REG_ADDR_WIDTH-1:0] rs1_addr;
        logic [REG_ADDR_WIDTH-1:0] rs2_addr;
        logic [REG_ADDR_WIDTH-1:0] rd_addr;
        logic                      rd_write_en;
    } decoded_t;

    // Result broadcast from the execution side
    typedef struct packed {
        logic                     valid;
        logic [ROB_TAG_WIDTH-1:0] rob_tag;
        logic [DATA_WIDTH-1:0]    data;
    } result_t;

    // In-order commit of the oldest ROB entry
    typedef struct packed {
        logic                      valid;
        logic [ROB_TAG_WIDTH-1:0]  rob_tag;
        logic [REG_ADDR_WIDTH-1:0] rd_addr;
    } commit_t;

    // Renamed instruction toward the reservation stations
    // q_* is the pending producer tag, v_* the ready operand value
    typedef struct packed {
        logic                      valid;
        logic [PC_WIDTH-1:0]       pc;
        instr_u                    instr;
        logic [ROB_TAG_WIDTH-1:0]  rob_tag;
        logic [REG_ADDR_WIDTH-1:0] rd_addr;
        logic                      rd_write_en;
        logic                      q_rs1_valid;
        logic [ROB_TAG_WIDTH-1:0]  q_rs1;
        logic [DATA_WIDTH-1:0]     v_rs1;
        logic                      q_rs2_valid;
        logic [ROB_TAG_WIDTH-1:0]  q_rs2;
        logic [DATA_WIDTH-1:0]     v_rs2;
    } dispatch_t;

endpackage

`default_nettype wire

//--- logic/register_renaming.sv
`default_nettype none

module register_renaming (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              flush_i,
    input  ooo_pkg::decoded_t                 decoded_i,
    input  logic [ooo_pkg::ROB_TAG_WIDTH-1:0] rob_new_tag_i,
    input  logic                              rob_ready_i,
    input  ooo_pkg::result_t                  result_i,
    input  ooo_pkg::commit_t                  commit_i,
    output logic                              accept_o,
    output ooo_pkg::dispatch_t                dispatch_o
);

    // Map table, one busy bit and producer tag per architectural register
    logic [ooo_pkg::ARCH_REG_COUNT-1:0]                              map_busy_q;
    logic [ooo_pkg::ARCH_REG_COUNT-1:0]                              map_busy_d;
    logic [ooo_pkg::ARCH_REG_COUNT-1:0][ooo_pkg::ROB_TAG_WIDTH-1:0] map_tag_q;
    logic [ooo_pkg::ARCH_REG_COUNT-1:0][ooo_pkg::ROB_TAG_WIDTH-1:0] map_tag_d;

    // Physical register file indexed by ROB tag, filled from the result bus
    logic [ooo_pkg::DATA_WIDTH-1:0] prf_q [ooo_pkg::ROB_SIZE];
    logic [ooo_pkg::ROB_SIZE-1:0]   prf_ready_q;
    logic [ooo_pkg::ROB_SIZE-1:0]   prf_ready_d;

    // New mapping for rd this cycle
    logic rename_en;

    // Instruction moves on only while the ROB has room
    assign accept_o  = decoded_i.valid && rob_ready_i;
    assign rename_en = accept_o && decoded_i.rd_write_en && (decoded_i.rd_addr != '0);

    // --------------------
    // Operand fetch
    // --------------------

    // Pending tag when the producer is in flight, value once it has written back
    function automatic void fetch_operand(
        input  logic [ooo_pkg::REG_ADDR_WIDTH-1:0] addr,
        output logic                               q_valid,
        output logic [ooo_pkg::ROB_TAG_WIDTH-1:0]  q_tag,
        output logic [ooo_pkg::DATA_WIDTH-1:0]     value
    );
        logic                              mapped;
        logic [ooo_pkg::ROB_TAG_WIDTH-1:0] tag;
        // x0 is hardwired, never renamed
        mapped  = map_busy_q[addr] && (addr != '0);
        tag     = map_tag_q[addr];
        q_valid = mapped && !prf_ready_q[tag];
        q_tag   = q_valid ? tag : '0;
        // Unmapped value lives in the architectural file, outside this block
        value   = (mapped && prf_ready_q[tag]) ? prf_q[tag] : '0;
    endfunction

    always_comb begin
        dispatch_o.valid       = accept_o;
        dispatch_o.pc          = decoded_i.pc;
        dispatch_o.instr       = decoded_i.instr;
        dispatch_o.rob_tag     = rob_new_tag_i;
        dispatch_o.rd_addr     = decoded_i.rd_addr;
        dispatch_o.rd_write_en = decoded_i.rd_write_en;
        fetch_operand(decoded_i.rs1_addr, dispatch_o.q_rs1_valid,
                      dispatch_o.q_rs1, dispatch_o.v_rs1);
        fetch_operand(decoded_i.rs2_addr, dispatch_o.q_rs2_valid,
                      dispatch_o.q_rs2, dispatch_o.v_rs2);
    end

    // --------------------
    // Next state
    // --------------------
    always_comb begin
        map_busy_d  = map_busy_q;
        map_tag_d   = map_tag_q;
        prf_ready_d = prf_ready_q;

        // Result snoop marks the producer tag ready
        if (result_i.valid) begin
            prf_ready_d[result_i.rob_tag] = 1'b1;
        end

        // Commit frees the mapping only if no newer writer took the register
        if (commit_i.valid && map_busy_q[commit_i.rd_addr]
            && (map_tag_q[commit_i.rd_addr] == commit_i.rob_tag)) begin
            map_busy_d[commit_i.rd_addr] = 1'b0;
        end

        // Dispatch last so it wins over commit on the same register
        if (rename_en) begin
            map_busy_d[decoded_i.rd_addr] = 1'b1;
            map_tag_d[decoded_i.rd_addr]  = rob_new_tag_i;
            prf_ready_d[rob_new_tag_i]    = 1'b0;
        end
    end

    // --------------------
    // State registers
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            map_busy_q  <= '0;
            map_tag_q   <= '0;
            prf_ready_q <= '0;
        end else if (flush_i) begin
            map_busy_q  <= '0;
            map_tag_q   <= '0;
            prf_ready_q <= '0;
        end else begin
            map_busy_q  <= map_busy_d;
            map_tag_q   <= map_tag_d;
            prf_ready_q <= prf_ready_d;
        end
    end

    // Data is only read behind its ready bit
    always_ff @(posedge clk_i) begin
        if (result_i.valid && !flush_i) begin
            prf_q[result_i.rob_tag] <= result_i.data;
        end
    end

    // x0 reads must stay zero through any rename sequence
    a_x0_never_busy: assert property (
        @(posedge clk_i) disable iff (!rst_ni)
        !map_busy_q[0]
    ) else $error("map entry for x0 became busy");

endmodule

`default_nettype wire

//--- logic/rename_top.sv
`default_nettype none

module rename_top (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         flush_i,
    input  logic                         instr_valid_i,
    input  logic [ooo_pkg::PC_WIDTH-1:0] pc_i,
    input  ooo_pkg::instr_u              instr_i,
    input  ooo_pkg::result_t             result_i,
    input  ooo_pkg::commit_t             commit_i,
    output ooo_pkg::dispatch_t           dispatch_o,
    output logic                         rob_ready_o
);

    ooo_pkg::decoded_t                 decoded;
    ooo_pkg::dispatch_t                dispatch_comb;
    logic [ooo_pkg::ROB_TAG_WIDTH-1:0] rob_new_tag;
    logic                              accept;

    // --------------------
    // Decode
    // --------------------
    instr_decoder u_decoder (
        .valid_i   (instr_valid_i),
        .pc_i      (pc_i),
        .instr_i   (instr_i),
        .decoded_o (decoded)
    );

    // --------------------
    // ROB tags
    // --------------------
    rob_tag_alloc u_alloc (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .flush_i     (flush_i),
        .alloc_i     (accept),
        .commit_i    (commit_i),
        .tag_o       (rob_new_tag),
        .rob_ready_o (rob_ready_o)
    );

    // Rename in the decode cycle, register toward the stations
    register_renaming u_rename (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_i       (flush_i),
        .decoded_i     (decoded),
        .rob_new_tag_i (rob_new_tag),
        .rob_ready_i   (rob_ready_o),
        .result_i      (result_i),
        .commit_i      (commit_i),
        .accept_o      (accept),
        .dispatch_o    (dispatch_comb)
    );

    dispatch_stage u_dispatch (
        .clk_i      (clk_i),
        .rst_ni     (rst_ni),
        .flush_i    (flush_i),
        .dispatch_i (dispatch_comb),
        .dispatch_o (dispatch_o)
    );

endmodule

`default_nettype wire

//--- logic/rob_tag_alloc.sv
`default_nettype none

module rob_tag_alloc (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    input  logic                              flush_i,
    input  logic                              alloc_i,
    input  ooo_pkg::commit_t                  commit_i,
    output logic [ooo_pkg::ROB_TAG_WIDTH-1:0] tag_o,
    output logic                              rob_ready_o
);

    // Head is the oldest live entry, tail the next tag to hand out
    logic [ooo_pkg::ROB_TAG_WIDTH-1:0] head_q;
    logic [ooo_pkg::ROB_TAG_WIDTH-1:0] tail_q;
    // One extra bit so a full ROB can be told apart from an empty one
    logic [ooo_pkg::ROB_TAG_WIDTH:0]   count_q;

    // --------------------
    // Pointers and count
    // --------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else if (flush_i) begin
            // Flush drops every in-flight entry
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
        end else begin
            // Pointers wrap on their own since ROB_SIZE is a power of two
            if (alloc_i) begin
                tail_q <= tail_q + 1'b1;
            end
            if (commit_i.valid) begin
                head_q <= head_q + 1'b1;
            end
            // Allocate and commit together leave the count unchanged
            case ({alloc_i, commit_i.valid})
                2'b10: count_q <= count_q + 1'b1;
                2'b01: count_q <= count_q - 1'b1;
                default: begin
                end
            endcase
        end
    end

    assign tag_o       = tail_q;
    assign rob_ready_o = (count_q < ooo_pkg::ROB_SIZE);

    // --------------------
    // Protocol checks
    // --------------------

    // Rename must not accept into a full ROB
    a_no_alloc_when_full: assert property (
        @(posedge clk_i) disable iff (!rst_ni || flush_i)
        alloc_i |-> rob_ready_o
    ) else $error("allocation while ROB is full");

    // Commit is in order, always the oldest entry
    a_commit_in_order: assert property (
        @(posedge clk_i) disable iff (!rst_ni || flush_i)
        commit_i.valid |-> (commit_i.rob_tag == head_q)
    ) else $error("commit tag is not the oldest ROB entry");

    a_no_commit_when_empty: assert property (
        @(posedge clk_i) disable iff (!rst_ni || flush_i)
        commit_i.valid |-> (count_q != '0)
    ) else $error("commit while ROB is empty");

endmodule

`default_nettype wire

//--- test/rename_input.txt
// id ival pc instr res_v res_tag res_data com_v com_tag com_rd flush (all hex)
// then expected: valid tag rd we q1v q1 v1 q2v q2 v2 rob_ready
1 1 00001000 00500093 0 0 00000000 0 0 00 0 1 0 01 1 0 0 00000000 0 0 00000000 1
1 1 00001004 00700113 0 0 00000000 0 0 00 0 1 1 02 1 0 0 00000000 0 0 00000000 1
1 1 00001008 00320023 0 0 00000000 0 0 00 0 1 2 00 0 0 0 00000000 0 0 00000000 1
1 1 0000100c 123452b7 0 0 00000000 0 0 00 0 1 3 05 1 0 0 00000000 0 0 00000000 1
2 1 00001010 00208333 0 0 00000000 0 0 00 0 1 4 06 1 1 0 00000000 1 1 00000000 1
2 1 00001014 005003b3 0 0 00000000 0 0 00 0 1 5 07 1 0 0 00000000 1 3 00000000 1
3 0 00001018 00000000 1 0 00000005 0 0 00 0 0 0 00 0 0 0 00000000 0 0 00000000 1
3 1 0000101c 00208433 1 1 00000007 0 0 00 0 1 6 08 1 0 0 00000005 1 1 00000000 1
3 1 00001020 001104b3 0 0 00000000 1 0 01 0 1 7 09 1 0 0 00000007 0 0 00000005 1
3 1 00001024 00900113 0 0 00000000 1 1 02 0 1 0 02 1 0 0 00000000 0 0 00000000 1
3 1 00001028 00010533 1 0 00000099 1 2 00 0 1 1 0a 1 1 0 00000000 0 0 00000000 1
3 1 0000102c 002105b3 0 0 00000000 1 3 05 0 1 2 0b 1 0 0 00000099 0 0 00000099 1
4 1 00001030 00508633 0 0 00000000 1 4 06 0 1 3 0c 1 0 0 00000000 0 0 00000000 1
4 1 00001034 00100393 0 0 00000000 0 0 00 0 1 4 07 1 0 0 00000000 0 0 00000000 0
4 0 00001038 00000000 0 0 00000000 1 5 07 0 0 0 00 0 0 0 00000000 0 0 00000000 1
4 1 0000103c 006386b3 0 0 00000000 0 0 00 0 1 5 0d 1 1 4 00000000 0 0 00000000 0
5 1 00001040 00300713 0 0 00000000 0 0 00 0 0 0 00 0 0 0 00000000 0 0 00000000 0
5 0 00001044 00000000 0 0 00000000 1 6 08 0 0 0 00 0 0 0 00000000 0 0 00000000 1
5 1 00001048 008707b3 0 0 00000000 0 0 00 0 1 6 0f 1 0 0 00000000 0 0 00000000 0
6 0 0000104c 00000000 0 0 00000000 0 0 00 1 0 0 00 0 0 0 00000000 0 0 00000000 1
6 1 00001050 00238833 0 0 00000000 0 0 00 0 1 0 10 1 0 0 00000000 0 0 00000000 1
7 1 00001054 010808b3 0 0 00000000 0 0 00 0 1 1 11 1 1 0 00000000 1 0 00000000 1
7 1 00001058 00100913 0 0 00000000 0 0 00 0 1 2 12 1 0 0 00000000 0 0 00000000 1
7 1 0000105c 00100993 0 0 00000000 0 0 00 0 1 3 13 1 0 0 00000000 0 0 00000000 1
7 1 00001060 00100a13 0 0 00000000 0 0 00 0 1 4 14 1 0 0 00000000 0 0 00000000 1
7 1 00001064 00100a93 0 0 00000000 0 0 00 0 1 5 15 1 0 0 00000000 0 0 00000000 1
7 1 00001068 00100b13 0 0 00000000 0 0 00 0 1 6 16 1 0 0 00000000 0 0 00000000 1
7 1 0000106c 00100b93 0 0 00000000 0 0 00 0 1 7 17 1 0 0 00000000 0 0 00000000 0
7 1 00001070 00100c13 0 0 00000000 0 0 00 0 0 0 00 0 0 0 00000000 0 0 00000000 0
7 0 00001074 00000000 0 0 00000000 1 0 10 0 0 0 00 0 0 0 00000000 0 0 00000000 1
7 1 00001078 01180cb3 0 0 00000000 0 0 00 0 1 0 19 1 0 0 00000000 1 1 00000000 0

//--- test/rename_tb.sv
`default_nettype none

module rename_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_VEC = 64;
    localparam int FIELDS  = 22;

    // One line of the vector file, stimulus then expected dispatch fields
    typedef struct packed {
        logic [7:0]       id;
        logic             instr_valid;
        logic [31:0]      pc;
        logic [31:0]      instr;
        ooo_pkg::result_t result;
        ooo_pkg::commit_t commit;
        logic             flush;
        logic             exp_valid;
        logic [2:0]       exp_tag;
        logic [4:0]       exp_rd;
        logic             exp_we;
        logic             exp_q1_valid;
        logic [2:0]       exp_q1;
        logic [31:0]      exp_v1;
        logic             exp_q2_valid;
        logic [2:0]       exp_q2;
        logic [31:0]      exp_v2;
        logic             exp_ready;
    } vector_t;

    logic                         clk;
    logic                         rst_n;
    logic                         flush;
    logic                         instr_valid;
    logic [ooo_pkg::PC_WIDTH-1:0] pc;
    ooo_pkg::instr_u              instr;
    ooo_pkg::result_t             result;
    ooo_pkg::commit_t             commit;
    ooo_pkg::dispatch_t           dispatch;
    logic                         rob_ready;

    vector_t vectors [MAX_VEC];
    int      vec_count    = 0;
    bit      load_ok      = 1'b1;
    int      error_count  = 0;
    int      test_errors  = 0;
    int      tests_passed = 0;
    int      tests_failed = 0;
    int      cycle_count  = 0;
    int      cycle_limit  = MAX_VEC + 20;

    rename_top u_dut (
        .clk_i         (clk),
        .rst_ni        (rst_n),
        .flush_i       (flush),
        .instr_valid_i (instr_valid),
        .pc_i          (pc),
        .instr_i       (instr),
        .result_i      (result),
        .commit_i      (commit),
        .dispatch_o    (dispatch),
        .rob_ready_o   (rob_ready)
    );

    // --------------------
    // Clock and watchdog
    // --------------------
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("Timeout: run went past %0d cycles without finishing", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    // --------------------
    // Helpers
    // --------------------

    // Comment and blank lines scan zero fields and are skipped
    task automatic load_vectors();
        int                 fd;
        int                 n;
        logic [8*256-1:0]   line;
        logic [31:0]        f [FIELDS];
        vector_t            v;
        fd = $fopen("test/rename_input.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the vector file test/rename_input.txt");
            load_ok = 1'b0;
            return;
        end
        line = '0;
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8], f[9], f[10],
                        f[11], f[12], f[13], f[14], f[15], f[16], f[17], f[18], f[19], f[20],
                        f[21]);
            if (n == FIELDS && vec_count < MAX_VEC) begin
                v.id             = f[0][7:0];
                v.instr_valid    = f[1][0];
                v.pc             = f[2];
                v.instr          = f[3];
                v.result.valid   = f[4][0];
                v.result.rob_tag = f[5][2:0];
                v.result.data    = f[6];
                v.commit.valid   = f[7][0];
                v.commit.rob_tag = f[8][2:0];
                v.commit.rd_addr = f[9][4:0];
                v.flush          = f[10][0];
                v.exp_valid      = f[11][0];
                v.exp_tag        = f[12][2:0];
                v.exp_rd         = f[13][4:0];
                v.exp_we         = f[14][0];
                v.exp_q1_valid   = f[15][0];
                v.exp_q1         = f[16][2:0];
                v.exp_v1         = f[17];
                v.exp_q2_valid   = f[18][0];
                v.exp_q2         = f[19][2:0];
                v.exp_v2         = f[20];
                v.exp_ready      = f[21][0];
                vectors[vec_count] = v;
                vec_count = vec_count + 1;
            end else if (n == FIELDS) begin
                $display("Vector file holds more than %0d vectors", MAX_VEC);
                load_ok = 1'b0;
            end else if (n > 0) begin
                $display("Vector line %0d has %0d fields instead of %0d", vec_count, n, FIELDS);
                load_ok = 1'b0;
            end
            line = '0;
        end
        $fclose(fd);
    endtask

    task automatic drive_vector(input vector_t v);
        instr_valid = v.instr_valid;
        pc          = v.pc;
        instr       = v.instr;
        result      = v.result;
        commit      = v.commit;
        flush       = v.flush;
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("[ERROR] %0t %s: got %h, expected %h", $time, name, actual, expected);
            error_count = error_count + 1;
            test_errors = test_errors + 1;
        end
    endtask

    // Payload is held from the last packet, only meaningful behind valid
    task automatic compare_dispatch(input vector_t v);
        check_value("rob_ready_o", rob_ready, v.exp_ready);
        check_value("dispatch_o.valid", dispatch.valid, v.exp_valid);
        if (v.exp_valid) begin
            // PC and instruction word ride through unchanged
            check_value("dispatch_o.pc", dispatch.pc, v.pc);
            check_value("dispatch_o.instr", dispatch.instr, v.instr);
            check_value("dispatch_o.rob_tag", dispatch.rob_tag, v.exp_tag);
            check_value("dispatch_o.rd_addr", dispatch.rd_addr, v.exp_rd);
            check_value("dispatch_o.rd_write_en", dispatch.rd_write_en, v.exp_we);
            check_value("dispatch_o.q_rs1_valid", dispatch.q_rs1_valid, v.exp_q1_valid);
            check_value("dispatch_o.q_rs1", dispatch.q_rs1, v.exp_q1);
            check_value("dispatch_o.v_rs1", dispatch.v_rs1, v.exp_v1);
            check_value("dispatch_o.q_rs2_valid", dispatch.q_rs2_valid, v.exp_q2_valid);
            check_value("dispatch_o.q_rs2", dispatch.q_rs2, v.exp_q2);
            check_value("dispatch_o.v_rs2", dispatch.v_rs2, v.exp_v2);
        end
    endtask

    // --------------------
    // Main sequence
    // --------------------
    initial begin
        $timeformat(-9, 0, " ns", 0);
        rst_n       = 1'b0;
        flush       = 1'b0;
        instr_valid = 1'b0;
        pc          = '0;
        instr       = '0;
        result      = '0;
        commit      = '0;

        load_vectors();
        // One cycle per vector plus margin for reset
        cycle_limit = vec_count + 20;

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        if (load_ok) begin
            for (int i = 0; i < vec_count; i++) begin
                drive_vector(vectors[i]);
                @(negedge clk);
                compare_dispatch(vectors[i]);
                // Test ends where the id changes
                if (i == vec_count - 1 || vectors[i + 1].id != vectors[i].id) begin
                    if (test_errors == 0) begin
                        $display("test %0d: ok", vectors[i].id);
                        tests_passed = tests_passed + 1;
                    end else begin
                        $display("test %0d: %0d mismatches", vectors[i].id, test_errors);
                        tests_failed = tests_failed + 1;
                    end
                    test_errors = 0;
                end
            end
        end
        drive_vector('0);

        $display("Tests passed: %0d, tests failed: %0d", tests_passed, tests_failed);
        if (load_ok && vec_count > 0 && tests_failed == 0 && error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
